/* hw/mbus_addr_if.sv */
`default_nettype none

interface mbus_addr_if
	import mbus_pkg::*;
();

	dyn_addr_t dyn_addr;
	logic addr_valid;
	logic prefix_match;     // combinational, valid and equal
	dyn_addr_t frame_prefix;
	logic wr_en;            // one-cycle strobe
	dyn_addr_t wr_addr;
	logic clr;              // one-cycle strobe, beats wr_en

	modport node (
		input  prefix_match,
		output frame_prefix, wr_en, wr_addr, clr
	);

	modport rf (
		output dyn_addr, addr_valid, prefix_match,
		input  frame_prefix, wr_en, wr_addr, clr
	);

endinterface

`default_nettype wire

/* hw/mbus_addr_rf.sv */
`default_nettype none

module mbus_addr_rf
	import mbus_pkg::*;
(
	input wire clkin,
	input wire arst_n,
	input wire iso_release,
	mbus_addr_if.rf addr_bus
);

	// the node may be power gated, so updates are only taken once it is released
	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			addr_bus.dyn_addr <= '0;
			addr_bus.addr_valid <= 1'b0;
		end else if (iso_release) begin
			if (addr_bus.clr) begin
				addr_bus.addr_valid <= 1'b0;
			end else if (addr_bus.wr_en) begin
				addr_bus.dyn_addr <= addr_bus.wr_addr;
				addr_bus.addr_valid <= 1'b1;
			end
		end
	end

	assign addr_bus.prefix_match = addr_bus.addr_valid &&
		(addr_bus.frame_prefix == addr_bus.dyn_addr);

	// strobes from the node must not meet an unknown register
	a_strobe_known: assert property (
		@(posedge clkin) disable iff (!arst_n)
		(addr_bus.wr_en || addr_bus.clr) |-> !$isunknown(addr_bus.addr_valid)
	);

	// enumeration traffic while isolated leaves the address alone
	a_iso_hold: assert property (
		@(posedge clkin) disable iff (!arst_n)
		!iso_release |=> $stable(addr_bus.dyn_addr) && $stable(addr_bus.addr_valid)
	);

endmodule

`default_nettype wire

/* hw/mbus_layer_wrapper.sv */
`default_nettype none

module mbus_layer_wrapper
	import mbus_pkg::*;
#(
	parameter int IDLE_GAP = 3,
	parameter int RETURN_TIMEOUT = 64
) (
	input wire clkin,
	input wire arst_n,
	input wire iso_release,
	input wire static_id_t address,

	input wire din,
	output logic dout,
	output logic clkout,

	input wire addr_t tx_addr,
	input wire data_t tx_data,
	input wire tx_req,
	input wire tx_pend,
	output logic tx_ack,
	output logic tx_succ,
	output logic tx_fail,
	input wire tx_resp_ack,

	output addr_t rx_addr,
	output data_t rx_data,
	output logic rx_req,
	input wire rx_ack,
	output logic rx_pend,
	output logic rx_fail,
	output logic rx_broadcast
);

	logic node_dout;
	logic node_drive;

	mbus_addr_if addr_bus ();

	assign clkout = clkin;  // bus clock passes straight on

	// power gated protocol node
	mbus_node #(
		.IDLE_GAP       (IDLE_GAP),
		.RETURN_TIMEOUT (RETURN_TIMEOUT)
	) n0 (
		.clkin        (clkin),
		.arst_n       (arst_n),
		.din          (din),
		.address      (address),
		.node_dout    (node_dout),
		.node_drive   (node_drive),
		.tx_addr      (tx_addr),
		.tx_data      (tx_data),
		.tx_req       (tx_req),
		.tx_pend      (tx_pend),
		.tx_ack       (tx_ack),
		.tx_succ      (tx_succ),
		.tx_fail      (tx_fail),
		.tx_resp_ack  (tx_resp_ack),
		.rx_addr      (rx_addr),
		.rx_data      (rx_data),
		.rx_req       (rx_req),
		.rx_ack       (rx_ack),
		.rx_pend      (rx_pend),
		.rx_fail      (rx_fail),
		.rx_broadcast (rx_broadcast),
		.addr_bus     (addr_bus)
	);

	// always on
	mbus_wire_ctrl #(
		.IDLE_GAP (IDLE_GAP)
	) lc0 (
		.clkin       (clkin),
		.arst_n      (arst_n),
		.din         (din),
		.node_dout   (node_dout),
		.node_drive  (node_drive),
		.iso_release (iso_release),
		.dout        (dout)
	);

	// always on, keeps the enumerated address
	mbus_addr_rf rf0 (
		.clkin       (clkin),
		.arst_n      (arst_n),
		.iso_release (iso_release),
		.addr_bus    (addr_bus)
	);

endmodule

`default_nettype wire

/* hw/mbus_node.sv */
`default_nettype none

module mbus_node
	import mbus_pkg::*;
#(
	parameter int IDLE_GAP = 3,
	parameter int RETURN_TIMEOUT = 64
) (
	input wire clkin,
	input wire arst_n,
	input wire din,
	input wire static_id_t address,
	output logic node_dout,
	output logic node_drive,

	input wire addr_t tx_addr,
	input wire data_t tx_data,
	input wire tx_req,
	input wire tx_pend,
	output logic tx_ack,
	output logic tx_succ,
	output logic tx_fail,
	input wire tx_resp_ack,

	output addr_t rx_addr,
	output data_t rx_data,
	output logic rx_req,
	input wire rx_ack,
	output logic rx_pend,
	output logic rx_fail,
	output logic rx_broadcast,

	mbus_addr_if.node addr_bus
);

	localparam int IDLE_W = $clog2(IDLE_GAP + 1);
	localparam int TMO_W = $clog2(RETURN_TIMEOUT + 1);

	node_state_e state;
	bit_pos_t bit_cnt;
	data_t shift_q;
	addr_t addr_q;              // address of the incoming frame
	addr_t tx_addr_q;
	logic tx_pend_q;
	logic tx_miss;              // pending word was not there in time
	logic rx_drop;              // overrun, rest of the frame is skipped
	logic [IDLE_W-1:0] idle_cnt;

	// copy of our own frame coming back around the ring
	logic ret_busy;
	logic ret_seen;
	logic ret_lost;
	bit_pos_t ret_pos;
	addr_t ret_addr;
	logic [TMO_W-1:0] tmo_cnt;

	logic is_bcast;
	logic is_enum;
	logic deliver;
	logic idle_ok;
	logic tx_ok;

	assign is_bcast = addr_q[7:4] == BCAST_PREFIX;
	assign is_enum = is_bcast && (addr_q[3:0] == ENUM_FU);
	assign deliver = (addr_bus.prefix_match || is_bcast) && !is_enum && !rx_drop;
	assign idle_ok = din && (idle_cnt == IDLE_W'(IDLE_GAP));
	assign tx_ok = ret_seen && !ret_lost && !tx_miss && (ret_addr == tx_addr_q);

	assign addr_bus.frame_prefix = addr_q[7:4];
	assign addr_bus.wr_addr = shift_q[3:0];
	// strobes last exactly the one cycle spent in rx_more
	assign addr_bus.wr_en = (state == node_rx_more) && is_enum &&
		(shift_q[31:28] == CMD_ASSIGN) && (shift_q[27:8] == address);
	assign addr_bus.clr = (state == node_rx_more) && is_enum &&
		(shift_q[31:28] == CMD_INVALIDATE);

	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			state <= node_idle;
			bit_cnt <= '0;
			shift_q <= '0;
			addr_q <= '0;
			tx_addr_q <= '0;
			tx_pend_q <= 1'b0;
			tx_miss <= 1'b0;
			rx_drop <= 1'b0;
			idle_cnt <= '0;
			ret_busy <= 1'b0;
			ret_seen <= 1'b0;
			ret_lost <= 1'b0;
			ret_pos <= '0;
			ret_addr <= '0;
			tmo_cnt <= '0;
			node_dout <= 1'b1;  // idle line
			node_drive <= 1'b0;
			tx_ack <= 1'b0;
			tx_succ <= 1'b0;
			tx_fail <= 1'b0;
			rx_addr <= '0;
			rx_data <= '0;
			rx_req <= 1'b0;
			rx_pend <= 1'b0;
			rx_fail <= 1'b0;
			rx_broadcast <= 1'b0;
		end else begin
			tx_ack <= 1'b0;
			node_dout <= din;   // forward unless a tx state overrides

			if (tx_resp_ack) begin
				tx_succ <= 1'b0;
				tx_fail <= 1'b0;
			end
			if (rx_ack) begin
				rx_req <= 1'b0;
				rx_fail <= 1'b0;
			end

			if (!din)
				idle_cnt <= '0;
			else if (idle_cnt != IDLE_W'(IDLE_GAP))
				idle_cnt <= idle_cnt + 1'b1;

			// the return starts while we are still sending
			if (node_drive) begin
				if (ret_busy) begin
					ret_pos <= ret_pos + 1'b1;
					if (ret_pos < ADDR_BITS)
						ret_addr <= {ret_addr[ADDR_W-2:0], din};
					if (ret_pos == MORE_POS) begin
						if (din) begin
							ret_pos <= ADDR_BITS;
						end else begin
							ret_busy <= 1'b0;
							ret_seen <= 1'b1;
						end
					end
				end else if (!ret_seen && !ret_lost) begin
					if (!din) begin
						ret_busy <= 1'b1;
						ret_pos <= '0;
					end else if (tmo_cnt == TMO_W'(RETURN_TIMEOUT)) begin
						ret_lost <= 1'b1;   // ring open
					end else begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
				end
			end

			case (state)
				node_idle: begin
					rx_drop <= 1'b0;
					if (!din) begin
						state <= node_rx_addr;  // start bit
						bit_cnt <= '0;
					end else if (tx_req && idle_ok && !tx_succ && !tx_fail) begin
						state <= node_tx_start;
						node_drive <= 1'b1;
						tx_ack <= 1'b1;
						tx_addr_q <= tx_addr;
						shift_q <= tx_data;
						tx_pend_q <= tx_pend;
						tmo_cnt <= '0;
					end
				end
				node_rx_addr: begin
					addr_q <= {addr_q[ADDR_W-2:0], din};
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == ADDR_BITS - 1'b1)
						state <= node_rx_data;
				end
				node_rx_data: begin
					shift_q <= {shift_q[DATA_W-2:0], din};
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == MORE_POS - 1'b1)
						state <= node_rx_more;
				end
				node_rx_more: begin
					if (deliver) begin
						if (rx_req && !rx_ack) begin
							rx_fail <= 1'b1;    // previous word still held
							rx_drop <= 1'b1;
						end else begin
							rx_req <= 1'b1;
							rx_addr <= addr_q;
							rx_data <= shift_q;
							rx_pend <= din;
							rx_broadcast <= is_bcast;
						end
					end
					if (din) begin
						state <= node_rx_data;
						bit_cnt <= ADDR_BITS;
					end else begin
						state <= node_idle;
					end
				end
				node_tx_start: begin
					node_dout <= 1'b0;
					bit_cnt <= '0;
					state <= node_tx_addr;
				end
				node_tx_addr: begin
					node_dout <= tx_addr_q[~bit_cnt[2:0]]; // msb first
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == ADDR_BITS - 1'b1)
						state <= node_tx_data;
				end
				node_tx_data: begin
					node_dout <= shift_q[DATA_W-1];
					shift_q <= {shift_q[DATA_W-2:0], 1'b0};
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == MORE_POS - 1'b1)
						state <= node_tx_more;
				end
				node_tx_more: begin
					if (tx_pend_q && tx_req) begin
						node_dout <= 1'b1;
						tx_ack <= 1'b1;
						shift_q <= tx_data;
						tx_pend_q <= tx_pend;
						bit_cnt <= ADDR_BITS;
						state <= node_tx_data;
					end else begin
						node_dout <= 1'b0;
						tx_miss <= tx_pend_q;
						state <= node_tx_wait_return;
					end
				end
				node_tx_wait_return: begin
					node_dout <= 1'b1;  // absorb the returning copy
					if (ret_seen || ret_lost)
						state <= node_tx_report;
				end
				node_tx_report: begin
					node_dout <= 1'b1;
					node_drive <= 1'b0;
					tx_succ <= tx_ok;
					tx_fail <= !tx_ok;
					tx_miss <= 1'b0;
					ret_busy <= 1'b0;
					ret_seen <= 1'b0;
					ret_lost <= 1'b0;
					state <= node_idle;
				end
				default: state <= node_idle;
			endcase
		end
	end

	a_tx_result_onehot: assert property (
		@(posedge clkin) disable iff (!arst_n)
		!(tx_succ && tx_fail)
	);

	// a held word waits for the user, whatever the bus does
	a_rx_req_hold: assert property (
		@(posedge clkin) disable iff (!arst_n)
		(rx_req && !rx_ack) |=> rx_req
	);

endmodule

`default_nettype wire

/* hw/mbus_pkg.sv */
`default_nettype none

package mbus_pkg;

	localparam int ADDR_W = 8;
	localparam int DYN_W = 4;
	localparam int DATA_W = 32;
	localparam int ID_W = 20;

	typedef logic [ADDR_W-1:0] addr_t;     // prefix in the upper nibble, fu below
	typedef logic [DYN_W-1:0] dyn_addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ID_W-1:0] static_id_t;  // fixed layer identity
	typedef logic [5:0] bit_pos_t;         // bit index counted after the start bit

	// frame address fields
	localparam dyn_addr_t BCAST_PREFIX = 4'hf;
	localparam logic [3:0] ENUM_FU = 4'h0;

	// enumeration commands in data[31:28]
	localparam logic [3:0] CMD_ASSIGN = 4'h2;
	localparam logic [3:0] CMD_INVALIDATE = 4'h3;

	// 8 address bits, then 32 data bits, then the more-bit at index 40
	localparam bit_pos_t ADDR_BITS = 6'd8;
	localparam bit_pos_t MORE_POS = 6'd40;

	typedef enum logic [3:0] {
		node_idle,
		node_rx_addr,
		node_rx_data,
		node_rx_more,
		node_tx_start,
		node_tx_addr,
		node_tx_data,
		node_tx_more,
		node_tx_wait_return,
		node_tx_report
	} node_state_e;

	typedef enum logic {
		wire_forward,
		wire_node_drive
	} wire_state_e;

endpackage

`default_nettype wire

/* hw/mbus_wire_ctrl.sv */
`default_nettype none

module mbus_wire_ctrl
	import mbus_pkg::*;
#(
	parameter int IDLE_GAP = 3
) (
	input wire clkin,
	input wire arst_n,
	input wire din,
	input wire node_dout,
	input wire node_drive,
	input wire iso_release,
	output logic dout
);

	localparam int IDLE_W = $clog2(IDLE_GAP + 1);

	wire_state_e state;
	wire_state_e want;
	logic fwd_q;
	logic in_frame;         // a frame is passing on din
	bit_pos_t pos;
	logic [IDLE_W-1:0] idle_cnt;
	logic gap_ok;

	assign want = iso_release ? wire_node_drive : wire_forward;
	assign gap_ok = !in_frame && !node_drive && din && (idle_cnt == IDLE_W'(IDLE_GAP));

	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			state <= wire_forward;
			fwd_q <= 1'b1;
			in_frame <= 1'b0;
			pos <= '0;
			idle_cnt <= '0;
		end else begin
			fwd_q <= din;

			// data bits may hold long runs of ones, so track frame length
			if (in_frame) begin
				pos <= pos + 1'b1;
				if (pos == MORE_POS) begin
					if (din)
						pos <= ADDR_BITS;
					else
						in_frame <= 1'b0;
				end
			end else if (!din) begin
				in_frame <= 1'b1;
				pos <= '0;
			end

			if (!din || in_frame)
				idle_cnt <= '0;
			else if (idle_cnt != IDLE_W'(IDLE_GAP))
				idle_cnt <= idle_cnt + 1'b1;

			if (gap_ok)
				state <= want;  // iso changes wait for the gap
		end
	end

	assign dout = (state == wire_node_drive) ? node_dout : fwd_q;

	a_no_switch_in_frame: assert property (
		@(posedge clkin) disable iff (!arst_n)
		(in_frame || node_drive) |=> $stable(state)
	);

endmodule

`default_nettype wire

/* list.f */
hw/mbus_pkg.sv
hw/mbus_addr_if.sv
hw/mbus_addr_rf.sv
hw/mbus_node.sv
hw/mbus_wire_ctrl.sv
hw/mbus_layer_wrapper.sv
testbench/mbus_checker.sv
testbench/tb_mbus_layer.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_mbus_layer -Mdir obj_dir
out=$(./obj_dir/Vtb_mbus_layer)
echo "$out"
echo "$out" | grep -q "NO ERRORS"

/* testbench/mbus_checker.sv */
`default_nettype none

module mbus_checker
	import mbus_pkg::*;
(
	input wire clkin,
	input wire arst_n,
	input wire din,
	input wire dout,
	input wire clkout,
	input wire iso_release,
	input wire static_id_t address,
	input wire fwd_check,   // compare dout against delayed din
	input wire ring_mode,   // own frames on the ring, no external traffic
	input wire exp_succ,
	input wire addr_t tx_addr,
	input wire data_t tx_data,
	input wire tx_ack,
	input wire tx_succ,
	input wire tx_fail,
	input wire tx_resp_ack,
	input wire addr_t rx_addr,
	input wire data_t rx_data,
	input wire rx_req,
	input wire rx_ack,
	input wire rx_pend,
	input wire rx_fail,
	input wire rx_broadcast,
	output int err_count
);

	timeunit 1ns;
	timeprecision 100ps;

	// layer model
	dyn_addr_t m_dyn;
	logic m_valid;
	logic m_held;          // rx word waiting for rx_ack
	logic m_fail;
	logic m_drop;

	// incoming frame parser
	int pst;
	int pcnt;
	addr_t paddr;
	data_t pdata;
	logic bc;
	logic en;
	logic dlv;

	// word expected on the rx port after a delivery
	logic cmp_due;
	addr_t e_addr;
	data_t e_data;
	logic e_pend;
	logic e_bcast;

	// outgoing frame parser
	logic [39:0] txq[$];
	int tst;
	int tcnt;
	addr_t taddr;
	data_t tdata;

	logic din_q;
	logic fwd_q;
	logic succ_q;
	logic fail_q;
	logic resp_q;

	// clkout seen in the middle of each clkin phase
	logic clkout_hi;
	logic clkout_lo;

	task automatic check_val(input string name, input logic [39:0] exp, input logic [39:0] got);
		if (exp !== got) begin
			$display("FAILED %s exp %h got %h", name, exp, got);
			err_count++;
		end
	endtask

	always @(clkin) begin
		#2;
		if (clkin)
			clkout_hi = clkout;
		else
			clkout_lo = clkout;
	end

	always @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			m_dyn = '0;
			m_valid = 1'b0;
			m_held = 1'b0;
			m_fail = 1'b0;
			m_drop = 1'b0;
			pst = 0;
			tst = 0;
			cmp_due = 1'b0;
			din_q = 1'b1;
			fwd_q = 1'b0;
			succ_q = 1'b0;
			fail_q = 1'b0;
			resp_q = 1'b0;
			txq.delete();
			err_count = 0;
		end else begin
			check_val("clkout", 40'(1'b1), 40'(clkout_hi));   // passes clkin straight on
			check_val("clkout", 40'(1'b0), 40'(clkout_lo));
			check_val("rx_req", 40'(m_held), 40'(rx_req));
			check_val("rx_fail", 40'(m_fail), 40'(rx_fail));
			if (cmp_due) begin
				check_val("rx_addr", 40'(e_addr), 40'(rx_addr));
				check_val("rx_data", 40'(e_data), 40'(rx_data));
				check_val("rx_pend", 40'(e_pend), 40'(rx_pend));
				check_val("rx_broadcast", 40'(e_bcast), 40'(rx_broadcast));
				cmp_due = 1'b0;
			end
			if (fwd_q && fwd_check)
				check_val("dout", 40'(din_q), 40'(dout));   // one cycle of delay
			din_q = din;
			fwd_q = fwd_check;

			if (rx_ack) begin
				m_held = 1'b0;
				m_fail = 1'b0;
			end

			if (!ring_mode) begin
				case (pst)
					0: if (!din) begin
						pst = 1;
						pcnt = 0;
					end
					1: begin
						paddr = {paddr[6:0], din};
						pcnt++;
						if (pcnt == 8) begin
							pst = 2;
							pcnt = 0;
						end
					end
					2: begin
						pdata = {pdata[30:0], din};
						pcnt++;
						if (pcnt == 32)
							pst = 3;
					end
					default: begin
						bc = paddr[7:4] == BCAST_PREFIX;
						en = bc && (paddr[3:0] == ENUM_FU);
						dlv = ((m_valid && paddr[7:4] == m_dyn) || bc) && !en && !m_drop;
						if (en && iso_release) begin    // isolated layer keeps its address
							if (pdata[31:28] == CMD_INVALIDATE) begin
								m_valid = 1'b0;
							end else if (pdata[31:28] == CMD_ASSIGN && pdata[27:8] == address) begin
								m_dyn = pdata[3:0];
								m_valid = 1'b1;
							end
						end
						if (dlv && m_held && !rx_ack) begin
							m_fail = 1'b1;
							m_drop = 1'b1;
						end else if (dlv) begin
							m_held = 1'b1;
							cmp_due = 1'b1;
							e_addr = paddr;
							e_data = pdata;
							e_pend = din;
							e_bcast = bc;
						end
						pcnt = 0;
						pst = din ? 2 : 0;
						if (!din)
							m_drop = 1'b0;
					end
				endcase
			end else begin
				pst = 0;
			end

			// own frames as they leave on dout
			if (tx_ack)
				txq.push_back({tx_addr, tx_data});
			if (ring_mode) begin
				case (tst)
					0: if (!dout) begin
						tst = 1;
						tcnt = 0;
					end
					1: begin
						taddr = {taddr[6:0], dout};
						tcnt++;
						if (tcnt == 8) begin
							if (txq.size() == 0) begin
								$display("frame left on dout without an acknowledged word");
								err_count++;
							end else begin
								check_val("dout address", 40'(txq[0][39:32]), 40'(taddr));
							end
							tst = 2;
							tcnt = 0;
						end
					end
					2: begin
						tdata = {tdata[30:0], dout};
						tcnt++;
						if (tcnt == 32) begin
							if (txq.size() != 0)
								check_val("dout data", 40'(txq.pop_front() & 40'hffffffff), 40'(tdata));
							tst = 3;
						end
					end
					default: begin
						check_val("dout more bit", 40'(txq.size() != 0), 40'(dout));
						tcnt = 0;
						tst = dout ? 2 : 0;
					end
				endcase
			end

			if ((tx_succ || tx_fail) && !(succ_q || fail_q)) begin
				check_val("tx_succ", 40'(exp_succ), 40'(tx_succ));
				check_val("tx_fail", 40'(!exp_succ), 40'(tx_fail));
			end
			if ((succ_q && !tx_succ || fail_q && !tx_fail) && !resp_q) begin
				$display("transmit result dropped before tx_resp_ack");
				err_count++;
			end
			succ_q = tx_succ;
			fail_q = tx_fail;
			resp_q = tx_resp_ack;
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_mbus_layer.sv */
`default_nettype none

module tb_mbus_layer
	import mbus_pkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	localparam static_id_t STATIC_ID = 20'h5a3c1;

	logic clkin;
	logic arst_n = 1'b0;
	logic iso_release = 1'b1;
	static_id_t address = STATIC_ID;
	logic din = 1'b1;
	logic dout;
	logic clkout;
	addr_t tx_addr = '0;
	data_t tx_data = '0;
	logic tx_req = 1'b0;
	logic tx_pend = 1'b0;
	logic tx_resp_ack = 1'b0;
	logic tx_ack;
	logic tx_succ;
	logic tx_fail;
	addr_t rx_addr;
	data_t rx_data;
	logic rx_req;
	logic rx_ack = 1'b0;
	logic rx_pend;
	logic rx_fail;
	logic rx_broadcast;

	logic fwd_check = 1'b0;
	logic ring_mode = 1'b0;
	logic exp_succ = 1'b0;
	logic hold_ack = 1'b0;
	logic ring_open = 1'b0;
	logic corrupt = 1'b0;      // flip one returning address bit
	logic inj_q = 1'b1;
	logic [31:0] dline = '1;   // ring delay line
	int ring_len = 8;
	int rcnt = 0;
	logic tap;
	int err_count;
	int tb_errs = 0;
	int tests = 0;
	int last_errs = 0;
	dyn_addr_t dyn;
	int k;

	mbus_layer_wrapper DUT (.*);
	mbus_checker chk (.*);

	initial begin
		clkin = 1'b0;
		forever #10 clkin = ~clkin;
	end

	assign tap = dline[ring_len-1];

	always @(posedge clkin) begin
		dline <= {dline[30:0], dout};
		if (!corrupt)
			rcnt <= 0;
		else if (rcnt == 0 && !tap)
			rcnt <= 1;
		else if (rcnt != 0 && rcnt < 63)
			rcnt <= rcnt + 1;
		if (!ring_mode)
			din <= inj_q;
		else if (ring_open)
			din <= 1'b1;
		else
			din <= tap ^ (corrupt && rcnt == 3);   // address bit 5 on the way back
	end

	always @(posedge clkin)
		rx_ack <= rx_req && !rx_ack && !hold_ack;   // user takes words promptly

	task automatic send_bit(input logic b);
		@(posedge clkin);
		inj_q <= b;
	endtask

	task automatic inject_frame(input addr_t a, input data_t first, input int nwords);
		data_t w;
		int i;
		int j;
		send_bit(1'b0);
		for (i = 7; i >= 0; i--)
			send_bit(a[i]);
		for (i = 0; i < nwords; i++) begin
			w = (i == 0) ? first : $urandom;
			for (j = 31; j >= 0; j--)
				send_bit(w[j]);
			send_bit(i < nwords - 1);
		end
		repeat (8) send_bit(1'b1);
	endtask

	task automatic note_timeout(input string what);
		$display("timeout while waiting for %s", what);
		tb_errs++;
	endtask

	task automatic release_ack_on_fail();
		int n;
		bit seen;
		seen = 0;
		for (n = 0; n < 200 && !seen; n++) begin
			@(posedge clkin);
			seen = rx_fail;
		end
		if (!seen)
			note_timeout("rx_fail");
		hold_ack <= 1'b0;   // later words of the frame must stay dropped
	endtask

	task automatic send_msg(input int nwords, input bit miss);
		int i;
		int n;
		bit got;
		@(posedge clkin);
		tx_addr <= addr_t'($urandom);
		tx_data <= $urandom;
		tx_pend <= (nwords > 1) || miss;
		tx_req <= 1'b1;
		for (i = 0; i < nwords; i++) begin
			got = 0;
			for (n = 0; n < 400 && !got; n++) begin
				@(posedge clkin);
				got = tx_ack;
			end
			if (!got)
				note_timeout("tx_ack");
			if (i < nwords - 1) begin
				tx_data <= $urandom;
				tx_pend <= (i + 1 < nwords - 1) || miss;
			end else begin
				tx_req <= 1'b0;
				tx_pend <= 1'b0;
			end
		end
		got = 0;
		for (n = 0; n < 600 && !got; n++) begin
			@(posedge clkin);
			got = tx_succ || tx_fail;
		end
		if (!got)
			note_timeout("tx_succ or tx_fail");
		repeat ($urandom_range(1, 5)) @(posedge clkin);
		tx_resp_ack <= 1'b1;
		@(posedge clkin);
		tx_resp_ack <= 1'b0;
		repeat (40) @(posedge clkin);  // let the delay line drain
	endtask

	task automatic end_test(input string name);
		int e;
		repeat (20) @(posedge clkin);
		e = err_count + tb_errs;
		tests++;
		$display("test %0d %s: %0d errors", tests, name, e - last_errs);
		last_errs = e;
	endtask

	initial begin
		void'($urandom(87));
		repeat (10) @(posedge clkin);
		arst_n <= 1'b1;
		repeat (10) @(posedge clkin);

		fwd_check <= 1'b1;
		for (k = 0; k < 5; k++)
			inject_frame({4'($urandom_range(0, 14)), 4'($urandom)}, $urandom, $urandom_range(1, 2));
		end_test("forwarding");

		dyn = 4'($urandom_range(2, 13));
		inject_frame({BCAST_PREFIX, ENUM_FU}, {CMD_ASSIGN, STATIC_ID, 4'h0, dyn}, 1);
		inject_frame({dyn, 4'($urandom)}, $urandom, 3);
		inject_frame({BCAST_PREFIX, ENUM_FU}, {CMD_ASSIGN, STATIC_ID ^ 20'h1, 4'h0, dyn ^ 4'h1}, 1);
		inject_frame({dyn, 4'($urandom)}, $urandom, 1);
		inject_frame({dyn ^ 4'h1, 4'($urandom)}, $urandom, 1);
		inject_frame({BCAST_PREFIX, ENUM_FU}, {CMD_INVALIDATE, 28'h0}, 1);
		inject_frame({dyn, 4'($urandom)}, $urandom, 2);
		end_test("enumeration");

		inject_frame({BCAST_PREFIX, 4'($urandom_range(1, 15))}, $urandom, 1);
		hold_ack <= 1'b1;
		fork
			inject_frame({BCAST_PREFIX, 4'($urandom_range(1, 15))}, $urandom, 3);
			release_ack_on_fail();
		join
		end_test("broadcast and overrun");

		fwd_check <= 1'b0;
		ring_mode <= 1'b1;
		exp_succ <= 1'b1;
		for (k = 0; k < 3; k++) begin
			ring_len = $urandom_range(4, 20);
			send_msg($urandom_range(1, 3), 1'b0);
		end
		end_test("transmit success");

		exp_succ <= 1'b0;
		corrupt <= 1'b1;
		send_msg(1, 1'b0);
		corrupt <= 1'b0;
		ring_open <= 1'b1;
		send_msg(2, 1'b0);
		ring_open <= 1'b0;
		send_msg(1, 1'b1);
		end_test("transmit failure");

		ring_mode <= 1'b0;
		fwd_check <= 1'b1;
		dyn = 4'($urandom_range(2, 13));
		inject_frame({BCAST_PREFIX, ENUM_FU}, {CMD_ASSIGN, STATIC_ID, 4'h0, dyn}, 1);
		fork
			inject_frame({dyn ^ 4'h1, 4'h5}, $urandom, 2);
			begin
				repeat (20) @(posedge clkin);
				iso_release <= 1'b0;
			end
		join
		inject_frame({BCAST_PREFIX, ENUM_FU}, {CMD_INVALIDATE, 28'h0}, 1);  // ignored while isolated
		fork
			inject_frame({dyn ^ 4'h1, 4'h6}, $urandom, 1);
			begin
				repeat (15) @(posedge clkin);
				iso_release <= 1'b1;
			end
		join
		inject_frame({dyn, 4'($urandom)}, $urandom, 1);
		end_test("isolation");

		$display("tests %0d, errors %0d", tests, err_count + tb_errs);
		if (err_count + tb_errs == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// whole run limit
	initial begin
		#5ms;
		$display("simulation did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire
